// ==== mipsPipe.f ====
+incdir+testbench
verilog/mipsPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/hazardUnit.sv
verilog/memWbStage.sv
verilog/mipsPipe.sv
testbench/mipsPipeTb.sv

// ==== testbench/mipsPipeProgs.svh ====
/*
 * Test program table for the MIPS pipeline testbench
 * Programs, initial data words and expected data words of each test
 */

localparam int numTests = 4;
localparam int dataWords = 8;

string testName [numTests] = '{"aluChain", "loadUse", "branch", "randomAlu"};
int progStart [numTests] = '{0, 17, 27, 39};
int progLen [numTests] = '{17, 10, 12, 15};
// Random test repeats with fresh operands
int runCount [numTests] = '{1, 1, 1, 4};
bit randOps [numTests] = '{0, 0, 0, 1};

logic [31:0] progWords [54] = '{
    // aluChain, every result feeds the next one
    immType(addiOp, 1, 0, 7), immType(addiOp, 2, 1, 5), rType(addFn, 3, 2, 1),
    rType(subFn, 4, 3, 2), rType(andFn, 5, 4, 3), rType(orFn, 6, 5, 4),
    rType(sltFn, 7, 5, 6), rType(subFn, 8, 5, 6), rType(sltFn, 9, 8, 7),
    immType(swOp, 9, 0, 0), immType(swOp, 3, 0, 4), immType(swOp, 4, 0, 8),
    immType(swOp, 5, 0, 12), immType(swOp, 6, 0, 16), immType(swOp, 7, 0, 20),
    immType(swOp, 8, 0, 24), haltWord,
    // loadUse, loaded value used on rs, on rt and as store data
    immType(addiOp, 3, 0, 'h55), immType(lwOp, 1, 0, 0), rType(addFn, 2, 1, 3),
    immType(swOp, 2, 0, 8), immType(lwOp, 4, 0, 4), immType(swOp, 4, 0, 12),
    immType(lwOp, 5, 0, 4), rType(addFn, 6, 3, 5), immType(swOp, 6, 0, 16), haltWord,
    // branch, taken BEQ over three sentinel stores, then a not-taken BEQ
    immType(addiOp, 1, 0, 5), immType(addiOp, 2, 0, 5), immType(addiOp, 9, 0, 'h5e5e),
    immType(beqOp, 2, 1, 3), immType(swOp, 9, 0, 0), immType(swOp, 9, 0, 4),
    immType(swOp, 9, 0, 8), immType(addiOp, 3, 0, 'h33), immType(beqOp, 3, 1, 1),
    immType(swOp, 3, 0, 12), immType(swOp, 1, 0, 16), haltWord,
    // randomAlu, operands come from data words 0 and 1
    immType(lwOp, 1, 0, 0), immType(lwOp, 2, 0, 4), rType(addFn, 3, 1, 2),
    rType(subFn, 4, 1, 2), rType(andFn, 5, 1, 2), rType(orFn, 6, 1, 2),
    rType(sltFn, 7, 1, 2), immType(swOp, 3, 0, 8), immType(swOp, 4, 0, 12),
    immType(swOp, 5, 0, 16), immType(swOp, 6, 0, 20), immType(swOp, 7, 0, 24),
    rType(sltFn, 8, 2, 1), immType(swOp, 8, 0, 28), haltWord
};

logic [31:0] initData [numTests][dataWords] = '{
    '{32'ha000_0000, 32'ha000_0001, 32'ha000_0002, 32'ha000_0003,
      32'ha000_0004, 32'ha000_0005, 32'ha000_0006, 32'ha000_0007},
    '{32'h1234_5678, 32'h0000_0100, 32'hb000_0002, 32'hb000_0003,
      32'hb000_0004, 32'hb000_0005, 32'hb000_0006, 32'hb000_0007},
    '{32'hc000_0000, 32'hc000_0001, 32'hc000_0002, 32'hc000_0003,
      32'hc000_0004, 32'hc000_0005, 32'hc000_0006, 32'hc000_0007},
    // Words 0 and 1 replaced by random operands
    '{32'h0000_0000, 32'h0000_0000, 32'hd000_0002, 32'hd000_0003,
      32'hd000_0004, 32'hd000_0005, 32'hd000_0006, 32'hd000_0007}
};

logic [31:0] expData [numTests][dataWords] = '{
    '{32'h0000_0001, 32'h0000_0013, 32'h0000_0007, 32'h0000_0003,
      32'h0000_0007, 32'h0000_0001, 32'hffff_fffc, 32'ha000_0007},
    '{32'h1234_5678, 32'h0000_0100, 32'h1234_56cd, 32'h0000_0100,
      32'h0000_0155, 32'hb000_0005, 32'hb000_0006, 32'hb000_0007},
    '{32'hc000_0000, 32'hc000_0001, 32'hc000_0002, 32'h0000_0033,
      32'h0000_0005, 32'hc000_0005, 32'hc000_0006, 32'hc000_0007},
    // Worked out from the operands at run time
    '{32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0}
};

// ==== testbench/mipsPipeTb.sv ====
/*
 * Testbench for the five-stage MIPS pipeline
 * Runs table-driven programs against instruction and data memory models,
 * checks reset and halt behavior and the final data memory image
 */
module mipsPipeTb;
    timeunit 1ns;
    timeprecision 1ps;
    import mipsPkg::*;

    localparam logic [31:0] resetPc = 32'h0000_0000;
    localparam int memWords = 256;

    // MIPS32 encodings
    localparam logic [5:0] addiOp = 6'h08;
    localparam logic [5:0] lwOp = 6'h23;
    localparam logic [5:0] swOp = 6'h2b;
    localparam logic [5:0] beqOp = 6'h04;
    localparam logic [5:0] addFn = 6'h20;
    localparam logic [5:0] subFn = 6'h22;
    localparam logic [5:0] andFn = 6'h24;
    localparam logic [5:0] orFn = 6'h25;
    localparam logic [5:0] sltFn = 6'h2a;
    localparam logic [31:0] haltWord = 32'hfc00_0000;

    function automatic logic [31:0] rType(logic [5:0] fn, int rd, int rs, int rt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
    endfunction

    // BEQ puts its second compare register in the rt slot
    function automatic logic [31:0] immType(logic [5:0] op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Signed compare as SLT defines it
    function automatic logic [31:0] sltRef(logic [31:0] x, logic [31:0] y);
        return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
    endfunction

    // Unused instruction words decode as HALT tagged with their address
    function automatic logic [31:0] imemFill(int idx);
        return {6'h3f, 18'h0, 8'(idx)};
    endfunction

    function automatic logic [31:0] dmemFill(int idx);
        return {16'hd00d, 8'h00, 8'(idx)};
    endfunction

    `include "mipsPipeProgs.svh"

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    dmemReqT     dmemReq;
    logic [31:0] dmemRData;
    logic        halt;

    logic [31:0] imem [memWords];
    logic [31:0] dmem [memWords];
    logic [31:0] initWords [dataWords];
    logic [31:0] expWords [dataWords];
    logic [31:0] rngState = 32'hc81756fa;
    int          cycles = 0;
    int          cycleLimit;

    mipsPipe #(
        .resetPc(resetPc),
        .forwardEn(1'b1)
    ) dut_i (
        .clk(clk),
        .rst(rst),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .dmemReq(dmemReq),
        .dmemRData(dmemRData),
        .halt(halt)
    );

    always #2 clk = ~clk;

    // Both memories answer in the same cycle, word addressed
    assign imemData = imem[imemAddr[9:2]];
    assign dmemRData = dmem[dmemReq.addr[9:2]];

    // Data memory reloads while reset is held
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < memWords; i++) begin
                if (i < dataWords) begin
                    dmem[i] <= initWords[i];
                end else begin
                    dmem[i] <= dmemFill(i);
                end
            end
        end else if (dmemReq.we) begin
            dmem[dmemReq.addr[9:2]] <= dmemReq.wData;
        end
    end

    task automatic failRun(string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(string name, string what, logic [31:0] expected,
                             logic [31:0] actual);
        assert (actual === expected)
        else failRun($sformatf("ERR %s %s expected %h actual %h", name, what, expected, actual));
    endtask

    task automatic checkCond(bit ok, string msg);
        assert (ok)
        else failRun(msg);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        assert (cycles < cycleLimit)
        else failRun($sformatf("timeout after %0d cycles, halt was never reached", cycles));
    end

    task automatic loadMemories(int t);
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < memWords; i++) begin
            if (i < progLen[t]) begin
                imem[i] = progWords[progStart[t] + i];
            end else begin
                imem[i] = imemFill(i);
            end
        end
        for (int i = 0; i < dataWords; i++) begin
            initWords[i] = initData[t][i];
            expWords[i] = expData[t][i];
        end
        if (randOps[t]) begin
            a = xorshift(rngState);
            b = xorshift(a);
            rngState = b;
            initWords[0] = a;
            initWords[1] = b;
            expWords[0] = a;
            expWords[1] = b;
            expWords[2] = a + b;
            expWords[3] = a - b;
            expWords[4] = a & b;
            expWords[5] = a | b;
            expWords[6] = sltRef(a, b);
            expWords[7] = sltRef(b, a);
        end
    endtask

    // Reset with the program loaded, run to halt, then watch the drain
    task automatic runProgram(int t);
        logic [31:0] frozenPc;
        @(negedge clk);
        rst = 1'b1;
        loadMemories(t);
        repeat (4) @(negedge clk);
        checkWord(testName[t], "imemAddr after reset", resetPc, imemAddr);
        checkCond(dmemReq.we === 1'b0 && dmemReq.re === 1'b0,
                  $sformatf("%s: data memory accessed during reset", testName[t]));
        checkCond(halt === 1'b0, $sformatf("%s: halt high right after reset", testName[t]));
        rst = 1'b0;
        while (halt !== 1'b1) begin
            @(negedge clk);
        end
        frozenPc = imemAddr;
        for (int k = 2; k <= 5; k++) begin
            @(negedge clk);
            checkCond(halt === 1'b1, $sformatf("%s: halt fell after rising", testName[t]));
            checkWord(testName[t], "imemAddr after halt", frozenPc, imemAddr);
            // Older stores are done by the third cycle
            if (k > 3) begin
                checkCond(dmemReq.we === 1'b0,
                          $sformatf("%s: data write %0d cycles after halt", testName[t], k));
            end
        end
    endtask

    // Whole memory, so stray stores and sentinels show up too
    task automatic compareMemory(int t);
        logic [31:0] expected;
        for (int i = 0; i < memWords; i++) begin
            if (i < dataWords) begin
                expected = expWords[i];
            end else begin
                expected = dmemFill(i);
            end
            checkWord(testName[t], $sformatf("dmem[%0d]", i), expected, dmem[i]);
        end
    endtask

    initial begin
        rst = 1'b1;
        cycleLimit = 40;
        for (int t = 0; t < numTests; t++) begin
            cycleLimit += 8 * progLen[t] * runCount[t];
        end
        for (int t = 0; t < numTests; t++) begin
            for (int r = 0; r < runCount[t]; r++) begin
                runProgram(t);
                compareMemory(t);
            end
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== verilog/decodeStage.sv ====
/*
 * Decode stage
 * Control decode, register file with writeback bypass, sign extension,
 * the ID/EX register and the sticky halt flag
 */
module decodeStage (
    input  logic                clk,
    input  logic                rst,
    input  mipsPkg::ifIdT       ifId,
    input  logic                stall,
    input  mipsPkg::redirectT   redirect,
    input  mipsPkg::memWbT      memWb,
    input  logic [31:0]         wbValue,
    output mipsPkg::idExT       idEx,
    output logic                halted
);
    import mipsPkg::*;

    logic [wordW-1:0] regFile [32];

    opcodeE              op;
    ctrlT                ctrl;
    logic [regAddrW-1:0] rs;
    logic [regAddrW-1:0] rt;
    logic [wordW-1:0]    rsVal;
    logic [wordW-1:0]    rtVal;
    logic [wordW-1:0]    imm;
    logic                bubble;

    assign op = getOpcode(ifId.instr);
    assign rs = getRs(ifId.instr);
    assign rt = getRt(ifId.instr);
    assign imm = {{16{ifId.instr[15]}}, getImm(ifId.instr)};

    // Main control
    always_comb begin
        ctrl = '0;
        ctrl.aluClass = classMemAdd;
        case (op)
            opRType: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst = 1'b1;
                ctrl.aluClass = classRFunct;
            end
            opAddi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluClass = classImmAdd;
            end
            opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluClass = classBranchSub;
            end
            // HALT and unknown opcodes do nothing
            default: ;
        endcase
    end

    // Register file write at the edge, r0 never written
    always_ff @(posedge clk) begin
        if (memWb.regWrite && memWb.dstReg != '0) begin
            regFile[memWb.dstReg] <= wbValue;
        end
    end

    // Reads see the value being written this cycle
    always_comb begin
        if (rs == '0) begin
            rsVal = '0;
        end else if (memWb.regWrite && memWb.dstReg == rs) begin
            rsVal = wbValue;
        end else begin
            rsVal = regFile[rs];
        end
        if (rt == '0) begin
            rtVal = '0;
        end else if (memWb.regWrite && memWb.dstReg == rt) begin
            rtVal = wbValue;
        end else begin
            rtVal = regFile[rt];
        end
    end

    // Bubble on load-use or RAW stall, on flush, and once halted
    assign bubble = stall || redirect.taken || halted;

    // Control and register numbers of ID/EX
    always_ff @(posedge clk) begin
        if (rst || bubble) begin
            idEx.ctrl <= '0;
            idEx.rs <= '0;
            idEx.rt <= '0;
            idEx.rd <= '0;
        end else begin
            idEx.ctrl <= ctrl;
            idEx.rs <= rs;
            idEx.rt <= rt;
            idEx.rd <= getRd(ifId.instr);
        end
    end

    // Payload of ID/EX
    always_ff @(posedge clk) begin
        idEx.pc4 <= ifId.pc4;
        idEx.rsVal <= rsVal;
        idEx.rtVal <= rtVal;
        idEx.imm <= imm;
        idEx.funct <= getFunct(ifId.instr);
    end

    // Sticky until reset, a flushed HALT does not count
    always_ff @(posedge clk) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (op == opHalt && !redirect.taken) begin
            halted <= 1'b1;
        end
    end

endmodule

// ==== verilog/executeStage.sv ====
/*
 * Execute stage
 * ALU control, ALU, forwarding operand muxes, branch target
 * and the EX/MEM register
 */
module executeStage (
    input  logic                clk,
    input  logic                rst,
    input  mipsPkg::idExT       idEx,
    input  mipsPkg::fwdSelE     fwdA,
    input  mipsPkg::fwdSelE     fwdB,
    input  logic [31:0]         wbValue,
    input  mipsPkg::redirectT   redirect,
    output mipsPkg::exMemT      exMem
);
    import mipsPkg::*;

    aluOpE               aluOp;
    logic [wordW-1:0]    opA;
    logic [wordW-1:0]    rtFwd;
    logic [wordW-1:0]    opB;
    logic [wordW-1:0]    aluResult;
    logic [wordW-1:0]    branchTarget;
    logic [regAddrW-1:0] dstReg;

    // ALU control from class and funct
    always_comb begin
        case (idEx.ctrl.aluClass)
            classBranchSub: aluOp = aluSub;
            classRFunct: begin
                case (idEx.funct)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    default: aluOp = aluAdd;
                endcase
            end
            // Address and ADDI both add
            default: aluOp = aluAdd;
        endcase
    end

    // Operand A, newest producer first
    always_comb begin
        case (fwdA)
            fromMem: opA = exMem.aluResult;
            fromWb:  opA = wbValue;
            default: opA = idEx.rsVal;
        endcase
    end

    // rt value, also the store data
    always_comb begin
        case (fwdB)
            fromMem: rtFwd = exMem.aluResult;
            fromWb:  rtFwd = wbValue;
            default: rtFwd = idEx.rtVal;
        endcase
    end

    assign opB = idEx.ctrl.aluSrc ? idEx.imm : rtFwd;

    always_comb begin
        case (aluOp)
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluSlt:  aluResult = {31'b0, $signed(opA) < $signed(opB)};
            default: aluResult = opA + opB;
        endcase
    end

    // Word offset relative to PC+4
    assign branchTarget = idEx.pc4 + {idEx.imm[wordW-3:0], 2'b00};
    // rd for R-type, rt for ADDI and LW
    assign dstReg = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

    // Control of EX/MEM, cleared when a branch in memory is taken
    always_ff @(posedge clk) begin
        if (rst || redirect.taken) begin
            exMem.regWrite <= 1'b0;
            exMem.memToReg <= 1'b0;
            exMem.memRead <= 1'b0;
            exMem.memWrite <= 1'b0;
            exMem.branch <= 1'b0;
        end else begin
            exMem.regWrite <= idEx.ctrl.regWrite;
            exMem.memToReg <= idEx.ctrl.memToReg;
            exMem.memRead <= idEx.ctrl.memRead;
            exMem.memWrite <= idEx.ctrl.memWrite;
            exMem.branch <= idEx.ctrl.branch;
        end
    end

    // Payload of EX/MEM
    always_ff @(posedge clk) begin
        exMem.aluResult <= aluResult;
        exMem.zero <= (aluResult == '0);
        exMem.storeData <= rtFwd;
        exMem.branchTarget <= branchTarget;
        exMem.dstReg <= dstReg;
    end

endmodule

// ==== verilog/fetchStage.sv ====
/*
 * Fetch stage
 * Program counter and the IF/ID register
 */
module fetchStage #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                halted,
    input  mipsPkg::redirectT   redirect,
    output logic [31:0]         imemAddr,
    input  logic [31:0]         imemData,
    output mipsPkg::ifIdT       ifId
);
    import mipsPkg::*;

    logic [wordW-1:0] pc;
    logic [wordW-1:0] pc4;

    assign pc4 = pc + wordW'(4);
    // Instruction memory answers in the same cycle
    assign imemAddr = pc;

    // Halt freezes fetch for good, a taken branch beats a stall
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
        end else if (!halted) begin
            if (redirect.taken) begin
                pc <= redirect.target;
            end else if (!stall) begin
                pc <= pc4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ifId <= '{pc4: '0, instr: nopInstr};
        end else if (!halted) begin
            if (redirect.taken) begin
                // Wrong-path instruction dropped
                ifId <= '{pc4: '0, instr: nopInstr};
            end else if (!stall) begin
                ifId <= '{pc4: pc4, instr: imemData};
            end
        end
    end

endmodule

// ==== verilog/hazardUnit.sv ====
/*
 * Hazard unit
 * Load-use and no-forwarding stall detection, operand forward selects
 */
module hazardUnit #(
    parameter bit forwardEn = 1'b1
) (
    input  mipsPkg::ifIdT       ifId,
    input  mipsPkg::idExT       idEx,
    input  mipsPkg::exMemT      exMem,
    input  mipsPkg::memWbT      memWb,
    output logic                stall,
    output mipsPkg::fwdSelE     fwdA,
    output mipsPkg::fwdSelE     fwdB
);
    import mipsPkg::*;

    logic [regAddrW-1:0] srcRs;
    logic [regAddrW-1:0] srcRt;
    logic                useRt;
    logic [regAddrW-1:0] exDst;
    logic                loadUse;
    logic                exRaw;
    logic                memRaw;

    // Source registers of the instruction in decode
    assign srcRs = getRs(ifId.instr);
    assign srcRt = getRt(ifId.instr);
    assign useRt = readsRt(getOpcode(ifId.instr));

    assign exDst = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

    // Destination feeds a source of the instruction in decode
    // Register 0 never counts
    function automatic logic hits(logic [regAddrW-1:0] dst);
        return dst != '0 && (dst == srcRs || (useRt && dst == srcRt));
    endfunction

    // Memory stage is newer than writeback and wins
    function automatic fwdSelE pick(logic [regAddrW-1:0] src);
        if (exMem.regWrite && exMem.dstReg != '0 && exMem.dstReg == src) begin
            return fromMem;
        end else if (memWb.regWrite && memWb.dstReg != '0 && memWb.dstReg == src) begin
            return fromWb;
        end
        return fromReg;
    endfunction

    // Dependencies on the instructions in execute and memory
    always_comb begin
        loadUse = idEx.ctrl.memRead && hits(idEx.rt);
        exRaw = idEx.ctrl.regWrite && hits(exDst);
        memRaw = exMem.regWrite && hits(exMem.dstReg);
    end

    always_comb begin
        if (forwardEn) begin
            stall = loadUse;
            fwdA = pick(idEx.rs);
            fwdB = pick(idEx.rt);
        end else begin
            // Wait until the producer reaches writeback
            stall = exRaw || memRaw;
            fwdA = fromReg;
            fwdB = fromReg;
        end
    end

endmodule

// ==== verilog/memWbStage.sv ====
/*
 * Memory and writeback stage
 * Branch decision, MEM/WB register and the writeback value
 */
module memWbStage (
    input  logic                clk,
    input  logic                rst,
    input  mipsPkg::exMemT      exMem,
    input  logic [31:0]         dmemRData,
    output mipsPkg::memWbT      memWb,
    output logic [31:0]         wbValue,
    output mipsPkg::redirectT   redirect
);
    import mipsPkg::*;

    // BEQ taken when the compare came out equal
    assign redirect.taken = exMem.branch & exMem.zero;
    assign redirect.target = exMem.branchTarget;

    always_ff @(posedge clk) begin
        if (rst) begin
            memWb.regWrite <= 1'b0;
            memWb.memToReg <= 1'b0;
        end else begin
            memWb.regWrite <= exMem.regWrite;
            memWb.memToReg <= exMem.memToReg;
        end
    end

    // Data read is combinational, captured at the edge
    always_ff @(posedge clk) begin
        memWb.readData <= dmemRData;
        memWb.aluResult <= exMem.aluResult;
        memWb.dstReg <= exMem.dstReg;
    end

    // Loads take memory data, everything else the ALU result
    assign wbValue = memWb.memToReg ? memWb.readData : memWb.aluResult;

endmodule

// ==== verilog/mipsPipe.sv ====
/*
 * Five-stage MIPS pipeline top level
 * Connects fetch, decode, execute, memory/writeback and the hazard unit,
 * and exposes the instruction and data memory ports
 */
module mipsPipe #(
    parameter logic [31:0] resetPc = 32'h0000_0000,
    parameter bit forwardEn = 1'b1
) (
    input  logic                clk,
    input  logic                rst,
    output logic [31:0]         imemAddr,
    input  logic [31:0]         imemData,
    output mipsPkg::dmemReqT    dmemReq,
    input  logic [31:0]         dmemRData,
    output logic                halt
);
    import mipsPkg::*;

    // Pipeline registers between the stages
    ifIdT     ifId;
    idExT     idEx;
    exMemT    exMem;
    memWbT    memWb;

    // Cross-stage control
    redirectT         redirect;
    logic             stall;
    logic             halted;
    fwdSelE           fwdA;
    fwdSelE           fwdB;
    logic [wordW-1:0] wbValue;

    fetchStage #(
        .resetPc(resetPc)
    ) fetch_i (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .halted(halted),
        .redirect(redirect),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .ifId(ifId)
    );

    decodeStage decode_i (
        .clk(clk),
        .rst(rst),
        .ifId(ifId),
        .stall(stall),
        .redirect(redirect),
        .memWb(memWb),
        .wbValue(wbValue),
        .idEx(idEx),
        .halted(halted)
    );

    executeStage execute_i (
        .clk(clk),
        .rst(rst),
        .idEx(idEx),
        .fwdA(fwdA),
        .fwdB(fwdB),
        .wbValue(wbValue),
        .redirect(redirect),
        .exMem(exMem)
    );

    memWbStage memWb_i (
        .clk(clk),
        .rst(rst),
        .exMem(exMem),
        .dmemRData(dmemRData),
        .memWb(memWb),
        .wbValue(wbValue),
        .redirect(redirect)
    );

    hazardUnit #(
        .forwardEn(forwardEn)
    ) hazard_i (
        .ifId(ifId),
        .idEx(idEx),
        .exMem(exMem),
        .memWb(memWb),
        .stall(stall),
        .fwdA(fwdA),
        .fwdB(fwdB)
    );

    // Memory stage drives data memory straight from EX/MEM
    assign dmemReq = '{
        addr:  exMem.aluResult,
        wData: exMem.storeData,
        we:    exMem.memWrite,
        re:    exMem.memRead
    };

    assign halt = halted;

endmodule

// ==== verilog/mipsPkg.sv ====
/*
 * MIPS pipeline shared definitions
 * Widths, instruction encodings, ALU operations, pipeline register
 * layouts and instruction field helpers
 */
package mipsPkg;

    localparam int wordW = 32;
    localparam int regAddrW = 5;

    // Primary opcode field
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b,
        opHalt  = 6'h3f
    } opcodeE;

    // R-type funct field
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functE;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOpE;

    // Coarse operation class chosen by decode, refined by funct in execute
    typedef enum logic [1:0] {classMemAdd, classBranchSub, classRFunct, classImmAdd} aluClassE;

    typedef enum logic [1:0] {fromReg, fromMem, fromWb} fwdSelE;

    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        logic     memRead;
        logic     memWrite;
        logic     branch;
        logic     aluSrc;
        logic     regDst;
        aluClassE aluClass;
    } ctrlT;

    typedef struct packed {
        logic [wordW-1:0] pc4;
        logic [wordW-1:0] instr;
    } ifIdT;

    typedef struct packed {
        ctrlT                ctrl;
        logic [wordW-1:0]    pc4;
        logic [wordW-1:0]    rsVal;
        logic [wordW-1:0]    rtVal;
        logic [wordW-1:0]    imm;
        logic [5:0]          funct;
        logic [regAddrW-1:0] rs;
        logic [regAddrW-1:0] rt;
        logic [regAddrW-1:0] rd;
    } idExT;

    typedef struct packed {
        logic                regWrite;
        logic                memToReg;
        logic                memRead;
        logic                memWrite;
        logic                branch;
        logic [wordW-1:0]    aluResult;
        logic                zero;
        logic [wordW-1:0]    storeData;
        logic [wordW-1:0]    branchTarget;
        logic [regAddrW-1:0] dstReg;
    } exMemT;

    typedef struct packed {
        logic                regWrite;
        logic                memToReg;
        logic [wordW-1:0]    readData;
        logic [wordW-1:0]    aluResult;
        logic [regAddrW-1:0] dstReg;
    } memWbT;

    typedef struct packed {
        logic             taken;
        logic [wordW-1:0] target;
    } redirectT;

    typedef struct packed {
        logic [wordW-1:0] addr;
        logic [wordW-1:0] wData;
        logic             we;
        logic             re;
    } dmemReqT;

    // Decodes as R-type with rd = 0, so nothing is written
    localparam logic [wordW-1:0] nopInstr = '0;

    function automatic opcodeE getOpcode(logic [wordW-1:0] instr);
        return opcodeE'(instr[31:26]);
    endfunction

    function automatic logic [regAddrW-1:0] getRs(logic [wordW-1:0] instr);
        return instr[25:21];
    endfunction

    function automatic logic [regAddrW-1:0] getRt(logic [wordW-1:0] instr);
        return instr[20:16];
    endfunction

    function automatic logic [regAddrW-1:0] getRd(logic [wordW-1:0] instr);
        return instr[15:11];
    endfunction

    function automatic logic [15:0] getImm(logic [wordW-1:0] instr);
        return instr[15:0];
    endfunction

    function automatic logic [5:0] getFunct(logic [wordW-1:0] instr);
        return instr[5:0];
    endfunction

    // rt is a source for R-type, store data and the BEQ compare
    function automatic logic readsRt(opcodeE op);
        return (op == opRType) || (op == opSw) || (op == opBeq);
    endfunction

endpackage
